// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // word memory behind the cache port
    localparam int mem_words    = 16;
    localparam int mem_idx_bits = 4;

    typedef logic [31:0] addr_t;

    typedef logic [3:0] byte_mask_t;

    // one data word, seen whole or as byte lanes
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } data_u;

    // addr holds a word address, low two bits are zero
    typedef struct packed {
        logic       valid;
        addr_t      addr;
        data_u      data;
        byte_mask_t byte_mask;
    } store_req_t;

    typedef struct packed {
        logic  valid;
        data_u data;
    } load_resp_t;

endpackage

`default_nettype wire

// File: hw/lsq_pkg.sv
`default_nettype none

package lsq_pkg;
    import mem_pkg::*;

    localparam int sq_size       = 8;
    localparam int sq_idx_bits   = 3;
    localparam int sq_count_bits = 4;

    // size codes of an issued store
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    // equal idx with different wrap bits means full
    typedef struct packed {
        logic                   wrap;
        logic [sq_idx_bits-1:0] idx;
    } sq_pointer;

    typedef struct packed {
        logic       resolved;
        addr_t      addr;
        byte_mask_t byte_mask;
        data_u      data;
    } sq_entry;

    typedef struct packed {
        logic                   valid;
        logic [sq_idx_bits-1:0] sq_idx;
        addr_t                  base;
        logic [11:0]            offset;
        logic [1:0]             size;
        logic [31:0]            data;
    } store_issue_t;

    // stores at or past sq_tail are younger than the load
    typedef struct packed {
        logic      valid;
        addr_t     addr;
        sq_pointer sq_tail;
    } load_req_t;

    typedef struct packed {
        logic                   valid;
        logic [sq_idx_bits-1:0] sq_idx;
        addr_t                  addr;
        byte_mask_t             byte_mask;
        data_u                  data;
    } sq_resolve_t;

endpackage

`default_nettype wire

// File: hw/store_unit.sv
`timescale 1ns/100ps
`default_nettype none

module store_unit
    import lsq_pkg::*;
    import mem_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  store_issue_t issue,
    output sq_resolve_t  resolve
);

    addr_t      store_addr;
    logic [1:0] lane;
    byte_mask_t mask;
    data_u      raw;
    data_u      lane_data;

    // offset is sign extended like an immediate
    assign store_addr = issue.base + {{20{issue.offset[11]}}, issue.offset};
    assign lane       = store_addr[1:0];

    always_comb begin
        case (issue.size)
            size_byte: mask = 4'b0001 << lane;
            size_half: mask = 4'b0011 << lane;
            size_word: mask = 4'b1111;
            default:   mask = 4'b0000;
        endcase
    end

    // low bytes of the raw word move up to the addressed lanes
    always_comb begin
        raw.word = issue.data;
        for (int i = 0; i < 4; i++) begin
            if (i >= int'(lane)) begin
                lane_data.bytes[i] = raw.bytes[i - int'(lane)];
            end else begin
                lane_data.bytes[i] = 8'h00;
            end
        end
    end

    always_ff @(posedge clock) begin
        resolve.sq_idx    <= issue.sq_idx;
        resolve.addr      <= {store_addr[31:2], 2'b00};
        resolve.byte_mask <= mask;
        resolve.data      <= lane_data;
        if (reset) begin
            resolve.valid <= 1'b0;
        end else begin
            resolve.valid <= issue.valid;
        end
    end

endmodule

`default_nettype wire

// File: hw/newest_store_select.sv
`timescale 1ns/100ps
`default_nettype none

module newest_store_select
    import lsq_pkg::*;
(
    input  logic [sq_size-1:0]     match,
    input  logic [sq_idx_bits-1:0] load_idx,
    output logic [sq_size-1:0]     pick
);

    logic [sq_size-1:0] rotated;
    logic [sq_size-1:0] grant;

    // top bit is the entry just older than the load
    always_comb begin
        for (int k = 0; k < sq_size; k++) begin
            rotated[k] = match[sq_idx_bits'(k + int'(load_idx))];
        end
    end

    // first set bit from the top is the youngest older match
    always_comb begin
        logic found;
        found = 1'b0;
        for (int k = sq_size - 1; k >= 0; k--) begin
            grant[k] = rotated[k] && !found;
            found    = found || rotated[k];
        end
    end

    always_comb begin
        for (int j = 0; j < sq_size; j++) begin
            pick[j] = grant[sq_idx_bits'(j - int'(load_idx))];
        end
    end

endmodule

`default_nettype wire

// File: hw/store_queue.sv
`timescale 1ns/100ps
`default_nettype none

module store_queue
    import lsq_pkg::*;
    import mem_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch,
    output logic [sq_count_bits-1:0] free_slots,
    output sq_pointer                dispatch_tail,
    input  sq_resolve_t              resolve,
    input  logic                     retire,
    input  logic                     restore_valid,
    input  sq_pointer                restore_tail,
    input  load_req_t                load_req,
    output data_u                    fwd_data,
    output byte_mask_t               fwd_mask,
    output store_req_t               store_req,
    input  logic                     accept
);

    sq_entry [sq_size-1:0] entries;

    sq_pointer tail;
    sq_pointer retire_head;
    sq_pointer drain_head;
    sq_pointer next_tail;
    sq_pointer next_drain_head;

    logic [sq_count_bits-1:0] count;
    logic [sq_count_bits-1:0] next_count;
    logic [sq_count_bits-1:0] drain_count;
    logic [sq_count_bits-1:0] squash_count;
    logic [sq_count_bits-1:0] load_span;
    logic [sq_count_bits-1:0] fwd_count;
    logic [sq_idx_bits-1:0]   restore_gap;
    logic                     dispatch_ok;

    logic [sq_size-1:0]      squashed;
    logic [sq_size-1:0]      in_window;
    logic [3:0][sq_size-1:0] lane_match;
    logic [3:0][sq_size-1:0] lane_pick;

    assign dispatch_ok   = dispatch && (count != sq_count_bits'(sq_size));
    assign free_slots    = sq_count_bits'(sq_size) - count;
    assign dispatch_tail = tail;

    // retired stores the cache has not taken yet
    assign drain_count = retire_head - drain_head;

    assign store_req.valid     = drain_count != '0;
    assign store_req.addr      = entries[drain_head.idx].addr;
    assign store_req.data      = entries[drain_head.idx].data;
    assign store_req.byte_mask = entries[drain_head.idx].byte_mask;

    assign next_drain_head = sq_pointer'(drain_head + accept);
    assign next_tail       = restore_valid ? restore_tail : sq_pointer'(tail + dispatch_ok);

    assign restore_gap = restore_tail.idx - next_drain_head.idx;

    always_comb begin
        if (restore_valid) begin
            if (restore_tail.idx == next_drain_head.idx &&
                restore_tail.wrap != next_drain_head.wrap) begin
                next_count = sq_count_bits'(sq_size);
            end else begin
                next_count = {1'b0, restore_gap};
            end
        end else begin
            next_count = count + sq_count_bits'(dispatch_ok) - sq_count_bits'(accept);
        end
    end

    assign squash_count = tail - restore_tail;

    // a load tail behind the drain head has nothing left to forward
    assign load_span = load_req.sq_tail - drain_head;
    assign fwd_count = (load_span > sq_count_bits'(sq_size)) ? '0 : load_span;

    always_comb begin
        logic [sq_idx_bits-1:0] rel_restore;
        logic [sq_idx_bits-1:0] rel_drain;
        for (int i = 0; i < sq_size; i++) begin
            rel_restore  = sq_idx_bits'(i) - restore_tail.idx;
            rel_drain    = sq_idx_bits'(i) - drain_head.idx;
            squashed[i]  = {1'b0, rel_restore} < squash_count;
            in_window[i] = {1'b0, rel_drain} < fwd_count;
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            for (int j = 0; j < sq_size; j++) begin
                lane_match[b][j] = load_req.valid && in_window[j] && entries[j].resolved &&
                                   entries[j].addr[31:2] == load_req.addr[31:2] &&
                                   entries[j].byte_mask[b];
            end
        end
    end

    for (genvar b = 0; b < 4; b++) begin : g_lane
        newest_store_select u_select (
            .match    (lane_match[b]),
            .load_idx (load_req.sq_tail.idx),
            .pick     (lane_pick[b])
        );
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            fwd_data.bytes[b] = 8'h00;
            fwd_mask[b]       = |lane_pick[b];
            for (int j = 0; j < sq_size; j++) begin
                if (lane_pick[b][j]) begin
                    fwd_data.bytes[b] = entries[j].data.bytes[b];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            tail        <= '0;
            retire_head <= '0;
            drain_head  <= '0;
            count       <= '0;
        end else begin
            tail        <= next_tail;
            retire_head <= sq_pointer'(retire_head + retire);
            drain_head  <= next_drain_head;
            count       <= next_count;
        end
    end

    // squash beats dispatch, which beats a late resolve
    always_ff @(posedge clock) begin
        for (int i = 0; i < sq_size; i++) begin
            if (resolve.valid && resolve.sq_idx == sq_idx_bits'(i)) begin
                entries[i].addr      <= resolve.addr;
                entries[i].byte_mask <= resolve.byte_mask;
                entries[i].data      <= resolve.data;
            end
            if (reset) begin
                entries[i].resolved <= 1'b0;
            end else if (restore_valid && squashed[i]) begin
                entries[i].resolved <= 1'b0;
            end else if (dispatch_ok && !restore_valid && tail.idx == sq_idx_bits'(i)) begin
                entries[i].resolved <= 1'b0;
            end else if (resolve.valid && resolve.sq_idx == sq_idx_bits'(i)) begin
                entries[i].resolved <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/data_cache_port.sv
`timescale 1ns/100ps
`default_nettype none

module data_cache_port
    import lsq_pkg::*;
    import mem_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  store_req_t store_req,
    output logic       accept,
    input  load_req_t  load_req,
    input  data_u      fwd_data,
    input  byte_mask_t fwd_mask,
    output load_resp_t load_resp
);

    data_u mem [mem_words];

    data_u                   merged;
    logic                    busy;
    logic [mem_idx_bits-1:0] store_idx;
    logic [mem_idx_bits-1:0] load_idx;

    // one idle cycle after every accepted store
    assign accept = store_req.valid && !busy;

    assign store_idx = store_req.addr[2 +: mem_idx_bits];
    assign load_idx  = load_req.addr[2 +: mem_idx_bits];

    // forwarded bytes are newer than memory
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (fwd_mask[b]) begin
                merged.bytes[b] = fwd_data.bytes[b];
            end else begin
                merged.bytes[b] = mem[load_idx].bytes[b];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            for (int w = 0; w < mem_words; w++) begin
                mem[w] <= '0;
            end
        end else begin
            busy <= accept;
            if (accept) begin
                for (int b = 0; b < 4; b++) begin
                    if (store_req.byte_mask[b]) begin
                        mem[store_idx].bytes[b] <= store_req.data.bytes[b];
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        load_resp.data <= merged;
        if (reset) begin
            load_resp.valid <= 1'b0;
        end else begin
            load_resp.valid <= load_req.valid;
        end
    end

endmodule

`default_nettype wire

// File: hw/lsq_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_top
    import lsq_pkg::*;
    import mem_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch,
    output logic [sq_count_bits-1:0] free_slots,
    output sq_pointer                dispatch_tail,
    input  store_issue_t             issue,
    input  logic                     retire,
    input  logic                     restore_valid,
    input  sq_pointer                restore_tail,
    input  load_req_t                load_req,
    output load_resp_t               load_resp
);

    sq_resolve_t resolve;
    store_req_t  store_req;
    logic        accept;
    data_u       fwd_data;
    byte_mask_t  fwd_mask;

    store_unit u_store_unit (
        .clock   (clock),
        .reset   (reset),
        .issue   (issue),
        .resolve (resolve)
    );

    store_queue u_store_queue (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .free_slots    (free_slots),
        .dispatch_tail (dispatch_tail),
        .resolve       (resolve),
        .retire        (retire),
        .restore_valid (restore_valid),
        .restore_tail  (restore_tail),
        .load_req      (load_req),
        .fwd_data      (fwd_data),
        .fwd_mask      (fwd_mask),
        .store_req     (store_req),
        .accept        (accept)
    );

    // loads see memory merged with bytes still in the queue
    data_cache_port u_data_cache_port (
        .clock     (clock),
        .reset     (reset),
        .store_req (store_req),
        .accept    (accept),
        .load_req  (load_req),
        .fwd_data  (fwd_data),
        .fwd_mask  (fwd_mask),
        .load_resp (load_resp)
    );

endmodule

`default_nettype wire

// File: verif/lsq_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_tb
    import lsq_pkg::*;
    import mem_pkg::*;
();

    logic                     clock;
    logic                     reset;
    logic                     dispatch;
    logic [sq_count_bits-1:0] free_slots;
    sq_pointer                dispatch_tail;
    store_issue_t             issue;
    logic                     retire;
    logic                     restore_valid;
    sq_pointer                restore_tail;
    load_req_t                load_req;
    load_resp_t               load_resp;

    // model pointers carry the wrap bit on top
    logic [3:0]  m_tail;
    logic [3:0]  m_retire;
    logic [3:0]  m_drain;
    logic [31:0] m_addr [sq_size];
    logic [3:0]  m_mask [sq_size];
    logic [31:0] m_data [sq_size];
    logic        m_res [sq_size];
    logic [31:0] base_mem [mem_words];

    logic [31:0] load_exp;
    logic [31:0] resp_exp;
    logic        resp_due;
    logic [3:0]  old_tail;

    int seed = 43;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int test_errors = 0;

    lsq_top dut (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .free_slots    (free_slots),
        .dispatch_tail (dispatch_tail),
        .issue         (issue),
        .retire        (retire),
        .restore_valid (restore_valid),
        .restore_tail  (restore_tail),
        .load_req      (load_req),
        .load_resp     (load_resp)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        #1_000_000;
        $display("simulation did not finish within its time limit");
        $display("TEST FAIL");
        $finish;
    end

    // a load sampled at one edge owes a response at the next
    always_ff @(posedge clock) begin
        resp_exp <= load_exp;
        if (reset) begin
            resp_due <= 1'b0;
        end else begin
            resp_due <= load_req.valid;
        end
    end

    assert property (@(posedge clock) disable iff (reset) load_resp.valid == resp_due)
        else begin
            $display("ERROR t=%0t load_resp.valid expected %b got %b",
                     $time, $sampled(resp_due), $sampled(load_resp.valid));
            errors++;
        end

    assert property (@(posedge clock) disable iff (reset)
                     resp_due |-> load_resp.data.word == resp_exp)
        else begin
            $display("ERROR t=%0t load_resp.data expected %h got %h",
                     $time, $sampled(resp_exp), $sampled(load_resp.data.word));
            errors++;
        end

    function automatic logic [3:0] span(input logic [3:0] young, input logic [3:0] old);
        return young - old;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  mask);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    // start from the memory image and apply resolved stores older than ltail in age order
    function automatic logic [31:0] expect_load(input logic [31:0] addr,
                                                input logic [3:0]  ltail);
        logic [31:0] result;
        logic [3:0]  p;
        result = base_mem[addr[5:2]];
        p = m_drain;
        for (int n = 0; n < sq_size; n++) begin
            if (p != ltail) begin
                if (m_res[p[2:0]] && m_addr[p[2:0]][31:2] == addr[31:2]) begin
                    result = merge_bytes(result, m_data[p[2:0]], m_mask[p[2:0]]);
                end
                p = p + 4'd1;
            end
        end
        return result;
    endfunction

    function automatic logic [3:0] first_unresolved();
        logic [3:0] p;
        p = m_retire;
        for (int k = 0; k < sq_size; k++) begin
            if (p != m_tail && m_res[p[2:0]]) begin
                p = p + 4'd1;
            end
        end
        return p;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR t=%0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // exact only when no retired store may still be draining
    task automatic check_slots();
        logic [3:0] least;
        least = 4'd8 - span(m_tail, m_drain);
        if (m_drain == m_retire) begin
            check_value("free_slots", {28'd0, least}, {28'd0, free_slots});
        end else begin
            checks++;
            assert (free_slots >= least) else begin
                $display("ERROR t=%0t free_slots expected at least %0d got %0d",
                         $time, least, free_slots);
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s done with %0d errors", tests, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic dispatch_store();
        @(posedge clock);
        dispatch <= 1'b1;
        @(posedge clock);
        dispatch <= 1'b0;
        m_res[m_tail[2:0]] = 1'b0;
        m_tail = m_tail + 4'd1;
        @(negedge clock);
        check_value("dispatch_tail", {28'd0, m_tail}, {28'd0, dispatch_tail});
        check_slots();
    endtask

    // returns once the resolve has written the entry
    task automatic issue_store(input logic [3:0] ptr, input logic [31:0] target,
                               input logic [1:0] size, input logic [31:0] raw);
        logic [11:0] off;
        logic [1:0]  lane;
        off = 12'($random(seed));
        lane = target[1:0];
        @(posedge clock);
        issue.valid  <= 1'b1;
        issue.sq_idx <= ptr[2:0];
        issue.base   <= target - {{20{off[11]}}, off};
        issue.offset <= off;
        issue.size   <= size;
        issue.data   <= raw;
        @(posedge clock);
        issue.valid <= 1'b0;
        @(posedge clock);
        m_addr[ptr[2:0]] = {target[31:2], 2'b00};
        m_data[ptr[2:0]] = raw << (8 * lane);
        m_res[ptr[2:0]] = 1'b1;
        if (size == size_byte) begin
            m_mask[ptr[2:0]] = 4'b0001 << lane;
        end else if (size == size_half) begin
            m_mask[ptr[2:0]] = 4'b0011 << lane;
        end else begin
            m_mask[ptr[2:0]] = 4'b1111;
        end
    endtask

    task automatic random_store(input logic [3:0] ptr);
        logic [1:0]  size;
        logic [31:0] target;
        size = 2'({$random(seed)} % 3);
        target = 32'($random(seed)) & 32'h0000_000f;
        if (size == size_half) begin
            target[0] = 1'b0;
        end else if (size == size_word) begin
            target[1:0] = 2'b00;
        end
        issue_store(ptr, target, size, $random(seed));
    endtask

    task automatic dispatch_and_issue(input logic [31:0] target, input logic [1:0] size);
        dispatch_store();
        issue_store(m_tail - 4'd1, target, size, $random(seed));
    endtask

    task automatic retire_store();
        @(posedge clock);
        retire <= 1'b1;
        @(posedge clock);
        retire <= 1'b0;
        m_retire = m_retire + 4'd1;
    endtask

    task automatic restore_queue(input logic [3:0] new_tail);
        logic [3:0] p;
        @(posedge clock);
        restore_valid <= 1'b1;
        restore_tail  <= new_tail;
        @(posedge clock);
        restore_valid <= 1'b0;
        p = new_tail;
        for (int n = 0; n < sq_size; n++) begin
            if (p != m_tail) begin
                m_res[p[2:0]] = 1'b0;
                p = p + 4'd1;
            end
        end
        m_tail = new_tail;
        @(negedge clock);
        check_value("dispatch_tail", {28'd0, m_tail}, {28'd0, dispatch_tail});
        check_slots();
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [3:0] ltail);
        logic [31:0] expected;
        int          waited;
        expected = expect_load(addr, ltail);
        @(posedge clock);
        load_req.valid   <= 1'b1;
        load_req.addr    <= addr;
        load_req.sq_tail <= ltail;
        load_exp         <= expected;
        @(posedge clock);
        load_req.valid <= 1'b0;
        checks++;
        for (waited = 0; waited < 8; waited++) begin
            @(negedge clock);
            if (load_resp.valid) begin
                break;
            end
        end
        if (waited == 8) begin
            $display("no load response arrived for address %h", addr);
            errors++;
        end
    endtask

    // once drained, retired stores move into the memory image
    task automatic wait_drained();
        logic [3:0] p;
        int         waited;
        for (waited = 0; waited < 64; waited++) begin
            @(negedge clock);
            if (free_slots == 4'd8 - span(m_tail, m_retire)) begin
                break;
            end
        end
        if (waited == 64) begin
            $display("store queue did not drain within 64 cycles");
            errors++;
        end
        p = m_drain;
        for (int n = 0; n < sq_size; n++) begin
            if (p != m_retire) begin
                base_mem[m_addr[p[2:0]][5:2]] = merge_bytes(base_mem[m_addr[p[2:0]][5:2]],
                                                            m_data[p[2:0]], m_mask[p[2:0]]);
                p = p + 4'd1;
            end
        end
        m_drain = m_retire;
    endtask

    task automatic drain_all();
        while (m_retire != m_tail) begin
            if (!m_res[m_retire[2:0]]) begin
                random_store(m_retire);
            end
            retire_store();
        end
        wait_drained();
        check_slots();
        for (int w = 0; w < 4; w++) begin
            load_word(32'(w * 4), m_tail);
        end
    endtask

    initial begin
        int         op;
        logic [3:0] ptr;
        reset = 1'b1;
        dispatch = 1'b0;
        issue = '0;
        retire = 1'b0;
        restore_valid = 1'b0;
        restore_tail = '0;
        load_req = '0;
        load_exp = '0;
        m_tail = '0;
        m_retire = '0;
        m_drain = '0;
        for (int i = 0; i < sq_size; i++) begin
            m_res[i] = 1'b0;
        end
        for (int w = 0; w < mem_words; w++) begin
            base_mem[w] = '0;
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);

        check_value("free_slots", 32'd8, {28'd0, free_slots});
        repeat (4) load_word($random(seed), m_tail);
        finish_test("reset");

        for (int n = 0; n < sq_size; n++) begin
            dispatch_store();
        end
        check_value("dispatch_tail.wrap", 32'd1, {31'd0, dispatch_tail.wrap});
        restore_queue(m_drain);
        finish_test("occupancy");

        dispatch_and_issue(32'h4, size_half);
        dispatch_and_issue(32'h5, size_byte);
        dispatch_and_issue(32'h8, size_word);
        dispatch_and_issue(32'hb, size_byte);
        load_word(32'h4, m_tail);
        load_word(32'h8, m_tail);
        old_tail = m_tail;
        dispatch_and_issue(32'h4, size_word);
        load_word(32'h4, old_tail);
        load_word(32'h4, m_tail);
        // the re-dispatched entry still holds the squashed word
        restore_queue(old_tail);
        dispatch_store();
        load_word(32'h4, m_tail);
        finish_test("forwarding");

        drain_all();
        finish_test("drain");

        dispatch_and_issue(32'h0, size_word);
        retire_store();
        wait_drained();
        old_tail = m_tail;
        dispatch_and_issue(32'h1, size_byte);
        dispatch_and_issue(32'h6, size_half);
        restore_queue(old_tail);
        load_word(32'h0, m_tail);
        load_word(32'h4, m_tail);
        drain_all();
        finish_test("restore");

        for (int n = 0; n < 400; n++) begin
            op = {$random(seed)} % 10;
            if (op < 3) begin
                if (span(m_tail, m_drain) == 4'd8 && m_retire != m_drain) begin
                    wait_drained();
                end
                if (span(m_tail, m_drain) != 4'd8) begin
                    dispatch_store();
                end
            end else if (op < 5) begin
                ptr = first_unresolved();
                if (ptr != m_tail) begin
                    random_store(ptr);
                end
            end else if (op < 7) begin
                if (m_retire != m_tail && m_res[m_retire[2:0]]) begin
                    retire_store();
                end
            end else if (op < 9) begin
                load_word(32'($random(seed)) & 32'h0000_000f, m_tail);
            end else begin
                ptr = m_retire + 4'({$random(seed)} % (int'(span(m_tail, m_retire)) + 1));
                restore_queue(ptr);
            end
        end
        drain_all();
        finish_test("random");

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/mem_pkg.sv
hw/lsq_pkg.sv
hw/store_unit.sv
hw/newest_store_select.sv
hw/store_queue.sv
hw/data_cache_port.sv
hw/lsq_top.sv
verif/lsq_tb.sv

// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module lsq_tb \
    -f filelist.f -o lsq_sim \
    && ./obj_dir/lsq_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "^TEST PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
